/* hw/l2_arb_atomic_pkg.sv */
/* Request kinds and LR reservation state.
   Compile before l2_arb_txn_pkg, which builds the request from l2_op_t. */
`include "l2_arb_settings.svh"

package l2_arb_atomic_pkg;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_lr    = 2'd2,
        op_sc    = 2'd3
    } l2_op_t;

    // One LR reservation, word granular
    typedef struct packed {
        logic                  valid;
        logic [`L2_ADDR_W-1:0] addr;
    } reservation_t;

endpackage

/* hw/l2_arb_txn_pkg.sv */
/* Transaction vector types shared by queues, arbiter and return path.
   The memory id is the port id placed above the requester tag. */
`include "l2_arb_settings.svh"

package l2_arb_txn_pkg;

    import l2_arb_atomic_pkg::*;

    localparam int PORT_ID_W = $clog2(`L2_NUM_PORTS);
    localparam int MEM_ID_W  = PORT_ID_W + `L2_TAG_W;

    typedef logic [`L2_ADDR_W-1:0] addr_t;
    typedef logic [`L2_DATA_W-1:0] data_t;
    typedef logic [`L2_TAG_W-1:0]  tag_t;
    typedef logic [PORT_ID_W-1:0]  port_id_t;

    // {port id, tag}
    typedef logic [MEM_ID_W-1:0] mem_id_t;

    // Single-word request, write data travels along
    typedef struct packed {
        addr_t  addr;
        l2_op_t kind;
        data_t  wdata;
        tag_t   tag;
    } l2_request_t;

endpackage

/* hw/l2_arbiter_top.sv */
/* Shared L2 memory port arbiter. Single-word requests only, LR/SC as the only
   atomics. Requesters must always accept read returns. */
`include "l2_arb_settings.svh"

module l2_arbiter_top
    import l2_arb_txn_pkg::*;
    import l2_arb_atomic_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // Requester side, indexed by port
    input  logic [`L2_NUM_PORTS-1:0] req_valid,
    output logic [`L2_NUM_PORTS-1:0] req_ready,
    input  addr_t                    req_addr [`L2_NUM_PORTS],
    input  l2_op_t                   req_op [`L2_NUM_PORTS],
    input  data_t                    req_wdata [`L2_NUM_PORTS],
    input  tag_t                     req_tag [`L2_NUM_PORTS],
    output logic [`L2_NUM_PORTS-1:0] sc_done,
    output logic [`L2_NUM_PORTS-1:0] sc_ok,
    output logic [`L2_NUM_PORTS-1:0] rsp_valid,
    output data_t                    rsp_data [`L2_NUM_PORTS],
    output tag_t                     rsp_tag [`L2_NUM_PORTS],
    // Memory request channel
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output addr_t                    mem_addr,
    output logic                     mem_write,
    output data_t                    mem_wdata,
    output mem_id_t                  mem_id,
    // Memory response channel, always accepted
    input  logic                     mem_rsp_valid,
    input  mem_id_t                  mem_rsp_id,
    input  data_t                    mem_rsp_data
);

    l2_queue_if  q_if [`L2_NUM_PORTS] ();
    l2_request_t in_req [`L2_NUM_PORTS];
    logic        check;
    port_id_t    check_port;
    addr_t       check_addr;
    l2_op_t      check_op;
    logic        table_sc_ok;

    for (genvar i = 0; i < `L2_NUM_PORTS; i++) begin : gen_port
        assign in_req[i] = '{
            addr:  req_addr[i],
            kind:  req_op[i],
            wdata: req_wdata[i],
            tag:   req_tag[i]
        };

        l2_port_queue queue (
            .clk     (clk),
            .rst     (rst),
            .in_valid(req_valid[i]),
            .in_ready(req_ready[i]),
            .in_req  (in_req[i]),
            .out     (q_if[i])
        );
    end

    l2_rr_arbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .queues       (q_if),
        .check        (check),
        .check_port   (check_port),
        .check_addr   (check_addr),
        .check_op     (check_op),
        .sc_ok_in     (table_sc_ok),
        .sc_done      (sc_done),
        .sc_ok        (sc_ok),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_addr     (mem_addr),
        .mem_write    (mem_write),
        .mem_wdata    (mem_wdata),
        .mem_id       (mem_id)
    );

    l2_reservation_table reservations (
        .clk       (clk),
        .rst       (rst),
        .check     (check),
        .check_port(check_port),
        .check_addr(check_addr),
        .check_op  (check_op),
        .sc_ok     (table_sc_ok)
    );

    l2_return_router router (
        .clk          (clk),
        .rst          (rst),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_id   (mem_rsp_id),
        .mem_rsp_data (mem_rsp_data),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .rsp_tag      (rsp_tag)
    );

endmodule

/* hw/l2_fifo.sv */
/* Synchronous FIFO, head entry read straight from the storage registers.
   A push while full is taken only together with a pop. */
module l2_fifo
    import l2_arb_txn_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  l2_request_t wr_data,
    output logic        full,
    input  logic        pop,
    output l2_request_t rd_data,
    output logic        not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    l2_request_t      entries [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign rd_data   = entries[rd_ptr];

    assign do_pop  = pop & not_empty;
    assign do_push = push & (~full | do_pop);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= wr_data;
        end
    end

endmodule

/* hw/l2_port_queue.sv */
/* One requester's request queue. in_ready is simply "not full", so it never
   depends on in_valid. Depth comes from L2_QUEUE_DEPTH. */
`include "l2_arb_settings.svh"

module l2_port_queue
    import l2_arb_txn_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  l2_request_t in_req,
    l2_queue_if.queue   out
);

    logic full;
    logic push;
    logic pop;

    // Requester handshake into the FIFO
    assign in_ready = ~full;
    assign push     = in_valid & ~full;

    // Arbiter takes the head on its handshake
    assign pop = out.valid & out.ready;

    l2_fifo #(
        .DEPTH(`L2_QUEUE_DEPTH)
    ) fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .wr_data  (in_req),
        .full     (full),
        .pop      (pop),
        .rd_data  (out.req),
        .not_empty(out.valid)
    );

endmodule

/* hw/l2_queue_if.sv */
/* Queue-to-arbiter handshake. Transfer when valid and ready are both high.
   req must hold while valid is high and ready is low. */
interface l2_queue_if
    import l2_arb_txn_pkg::*;
();

    logic        valid;
    logic        ready;
    l2_request_t req;

    // Port queue side, presents the head entry
    modport queue (
        output valid,
        output req,
        input  ready
    );

    // Arbiter side, ready doubles as the grant
    modport arbiter (
        input  valid,
        input  req,
        output ready
    );

endinterface

/* hw/l2_reservation_table.sv */
/* One LR reservation per port, word granular. sc_ok is combinational and only
   meaningful for an SC check. State changes on the check edge. */
`include "l2_arb_settings.svh"

module l2_reservation_table
    import l2_arb_txn_pkg::*;
    import l2_arb_atomic_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     check,
    input  port_id_t check_port,
    input  addr_t    check_addr,
    input  l2_op_t   check_op,
    output logic     sc_ok
);

    reservation_t resv [`L2_NUM_PORTS];
    logic         store;

    // Checking port holds a live reservation on this word
    assign sc_ok = resv[check_port].valid && (resv[check_port].addr == check_addr);

    // Anything that changes memory at the address
    assign store = check && ((check_op == op_write) || (check_op == op_sc && sc_ok));

    for (genvar i = 0; i < `L2_NUM_PORTS; i++) begin : gen_entry
        logic own;
        logic set_resv;
        logic clear_resv;

        assign own        = check && (check_port == port_id_t'(i));
        assign set_resv   = own && (check_op == op_lr);
        // Every SC ends the port's own reservation, pass or fail
        assign clear_resv = (own && check_op == op_sc)
                          || (store && resv[i].addr == check_addr);

        always_ff @(posedge clk) begin
            if (rst) begin
                resv[i] <= '0;
            end else if (set_resv) begin
                resv[i].valid <= 1'b1;
                resv[i].addr  <= check_addr;
            end else if (clear_resv) begin
                resv[i].valid <= 1'b0;
            end
        end
    end

endmodule

/* hw/l2_return_router.sv */
/* Read return routing by memory id, one cycle of latency, no back-pressure.
   Data and tag are shared by all ports and qualified by the one-hot valid. */
`include "l2_arb_settings.svh"

module l2_return_router
    import l2_arb_txn_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_rsp_valid,
    input  mem_id_t                  mem_rsp_id,
    input  data_t                    mem_rsp_data,
    output logic [`L2_NUM_PORTS-1:0] rsp_valid,
    output data_t                    rsp_data [`L2_NUM_PORTS],
    output tag_t                     rsp_tag [`L2_NUM_PORTS]
);

    port_id_t rsp_port;
    tag_t     rsp_tag_in;
    data_t    data_q;
    tag_t     tag_q;

    assign {rsp_port, rsp_tag_in} = mem_rsp_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= '0;
        end else begin
            for (int i = 0; i < `L2_NUM_PORTS; i++) begin
                rsp_valid[i] <= mem_rsp_valid && (rsp_port == port_id_t'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rsp_valid) begin
            data_q <= mem_rsp_data;
            tag_q  <= rsp_tag_in;
        end
    end

    for (genvar i = 0; i < `L2_NUM_PORTS; i++) begin : gen_port
        assign rsp_data[i] = data_q;
        assign rsp_tag[i]  = tag_q;
    end

endmodule

/* hw/l2_rr_arbiter.sv */
/* Round-robin grant over the port queues into a single memory request register.
   Grant is combinational. A failed SC is consumed here and never reaches memory. */
`include "l2_arb_settings.svh"

module l2_rr_arbiter
    import l2_arb_txn_pkg::*;
    import l2_arb_atomic_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    l2_queue_if.arbiter              queues [`L2_NUM_PORTS],
    output logic                     check,
    output port_id_t                 check_port,
    output addr_t                    check_addr,
    output l2_op_t                   check_op,
    input  logic                     sc_ok_in,
    output logic [`L2_NUM_PORTS-1:0] sc_done,
    output logic [`L2_NUM_PORTS-1:0] sc_ok,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output addr_t                    mem_addr,
    output logic                     mem_write,
    output data_t                    mem_wdata,
    output mem_id_t                  mem_id
);

    localparam int N = `L2_NUM_PORTS;

    logic [N-1:0] q_valid;
    l2_request_t  q_req [N];
    logic [N-1:0] grant_oh;
    port_id_t     last_grant;
    port_id_t     grant_port;
    logic         found;
    logic         slot_free;
    logic         grant;
    logic         is_sc;
    logic         forward;
    l2_request_t  g_req;

    for (genvar i = 0; i < N; i++) begin : gen_queue
        assign q_valid[i]      = queues[i].valid;
        assign q_req[i]        = queues[i].req;
        assign queues[i].ready = grant_oh[i];
    end

    // Search starts one past the last grant
    always_comb begin
        int unsigned idx;
        found      = 1'b0;
        grant_port = last_grant;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last_grant) + k) % N;
            if (!found && q_valid[idx]) begin
                found      = 1'b1;
                grant_port = port_id_t'(idx);
            end
        end
    end

    assign slot_free = ~mem_req_valid | mem_req_ready;
    assign grant     = found & slot_free;
    assign g_req     = q_req[grant_port];

    always_comb begin
        grant_oh = '0;
        if (grant) begin
            grant_oh[grant_port] = 1'b1;
        end
    end

    // Reservation lookup for the granted request
    assign check      = grant;
    assign check_port = grant_port;
    assign check_addr = g_req.addr;
    assign check_op   = g_req.kind;

    assign is_sc   = (g_req.kind == op_sc);
    assign forward = grant & (~is_sc | sc_ok_in);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant    <= '0;
            mem_req_valid <= 1'b0;
            sc_done       <= '0;
        end else begin
            if (grant) begin
                last_grant <= grant_port;
            end
            if (forward) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_ready) begin
                mem_req_valid <= 1'b0;
            end
            sc_done <= (grant && is_sc) ? grant_oh : '0;
        end
    end

    // SC result only meaningful alongside sc_done
    always_ff @(posedge clk) begin
        if (grant && is_sc) begin
            sc_ok[grant_port] <= sc_ok_in;
        end
    end

    // Forwarded SC has already passed, so it goes out as a plain write
    always_ff @(posedge clk) begin
        if (forward) begin
            mem_addr  <= g_req.addr;
            mem_write <= (g_req.kind == op_write) | is_sc;
            mem_wdata <= g_req.wdata;
            mem_id    <= {grant_port, g_req.tag};
        end
    end

endmodule

/* include/l2_arb_settings.svh */
/* Build-time sizing for the L2 port arbiter.
   L2_NUM_PORTS must be at least 2. The port id width is derived from it. */
`ifndef L2_ARB_SETTINGS_SVH
`define L2_ARB_SETTINGS_SVH

// Requesters sharing the memory port
`define L2_NUM_PORTS 4

// Entries in each requester queue
`define L2_QUEUE_DEPTH 4

// Word address, no byte offset
`define L2_ADDR_W 30

`define L2_DATA_W 32

// Requester-chosen tag, echoed on read return
`define L2_TAG_W 3

`endif

/* l2_arbiter.f */
+incdir+include
hw/l2_arb_atomic_pkg.sv
hw/l2_arb_txn_pkg.sv
hw/l2_queue_if.sv
hw/l2_fifo.sv
hw/l2_port_queue.sv
hw/l2_rr_arbiter.sv
hw/l2_reservation_table.sv
hw/l2_return_router.sv
hw/l2_arbiter_top.sv
test/l2_arbiter_assertions.sv
test/l2_arbiter_tb.sv

/* test/l2_arbiter_assertions.sv */
/* Memory channel and response checks for l2_arbiter_top.
   All checks are off while rst is high. */
`include "l2_arb_settings.svh"

module l2_arbiter_assertions
    import l2_arb_txn_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic                     mem_req_valid,
    input logic                     mem_req_ready,
    input addr_t                    mem_addr,
    input logic                     mem_write,
    input data_t                    mem_wdata,
    input mem_id_t                  mem_id,
    input logic [`L2_NUM_PORTS-1:0] rsp_valid,
    input logic [`L2_NUM_PORTS-1:0] sc_done
);

    int fail_count = 0;

    // Stalled request holds every field
    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr)
            && $stable(mem_write) && $stable(mem_wdata) && $stable(mem_id))
    else begin
        fail_count++;
        $error("memory request changed while stalled");
    end

    // Single return path, one port per cycle
    assert property (@(posedge clk) disable iff (rst) $onehot0(rsp_valid))
    else begin
        fail_count++;
        $error("read return on more than one port");
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(sc_done))
    else begin
        fail_count++;
        $error("SC result on more than one port");
    end

endmodule

bind l2_arbiter_top l2_arbiter_assertions checks (.*);

/* test/l2_arbiter_tb.sv */
/* Testbench for l2_arbiter_top with a 64-word memory model (address bits
   above 5 ignored), 3-cycle read latency and random mem_req_ready stalls. */
`include "l2_arb_settings.svh"

module l2_arbiter_tb
    import l2_arb_txn_pkg::*;
    import l2_arb_atomic_pkg::*;
();

    localparam int N       = `L2_NUM_PORTS;
    localparam int TIMEOUT = 200;

    typedef struct {
        port_id_t port;
        l2_op_t   op;
        addr_t    addr;
        data_t    wdata;
        tag_t     tag;
        data_t    result;
    } entry_t;

    logic         clk;
    logic         rst;
    logic [N-1:0] req_valid;
    logic [N-1:0] req_ready;
    addr_t        req_addr [N];
    l2_op_t       req_op [N];
    data_t        req_wdata [N];
    tag_t         req_tag [N];
    logic [N-1:0] sc_done;
    logic [N-1:0] sc_ok;
    logic [N-1:0] rsp_valid;
    data_t        rsp_data [N];
    tag_t         rsp_tag [N];
    logic         mem_req_valid;
    logic         mem_req_ready;
    addr_t        mem_addr;
    logic         mem_write;
    data_t        mem_wdata;
    mem_id_t      mem_id;
    logic         mem_rsp_valid;
    mem_id_t      mem_rsp_id;
    data_t        mem_rsp_data;

    // Memory model state
    integer       seed = 32'h6a48;
    data_t        mem_model [64];
    logic         pipe_v [3];
    mem_id_t      pipe_id [3];
    data_t        pipe_data [3];
    logic         mem_hs;
    mem_id_t      hs_ids [$];
    mem_id_t      last_wr_id;
    int           hs_count = 0;
    int           wr_count = 0;
    int           rsp_total = 0;
    int           expected_hs = 0;
    int           expected_rsp = 0;
    entry_t       stim_table [$];

    l2_arbiter_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic data_t fill_word(input int a);
        return data_t'(32'h5a00_0000 + a * 32'h0001_0101);
    endfunction

    // Handshake sampled mid-cycle and outputs driven just after the edge
    always @(negedge clk) begin
        mem_hs = !rst && mem_req_valid && mem_req_ready;
        for (int k = 2; k > 0; k--) begin
            pipe_v[k]    = pipe_v[k-1];
            pipe_id[k]   = pipe_id[k-1];
            pipe_data[k] = pipe_data[k-1];
        end
        pipe_v[0]    = mem_hs && !mem_write;
        pipe_id[0]   = mem_id;
        pipe_data[0] = mem_model[mem_addr[5:0]];
        if (mem_hs) begin
            hs_count++;
            hs_ids.push_back(mem_id);
            if (mem_write) begin
                mem_model[mem_addr[5:0]] = mem_wdata;
                wr_count++;
                last_wr_id = mem_id;
            end
        end
        @(posedge clk);
        #1;
        mem_rsp_valid = pipe_v[2];
        mem_rsp_id    = pipe_id[2];
        mem_rsp_data  = pipe_data[2];
        // Ready about three cycles in four
        mem_req_ready = ($random(seed) & 3) != 0;
    end

    always @(negedge clk) begin
        if (!rst) begin
            rsp_total += $countones(rsp_valid);
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped on first error");
    endtask

    // Stop at the first protocol assertion failure
    always @(negedge clk) begin
        if (uut.checks.fail_count != 0) begin
            stop_run("A protocol assertion on the memory or response side failed");
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at time %0t: %s data %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at time %0t: %s tag %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_sc(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at time %0t: %s SC result %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_port(input port_id_t got, input port_id_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at time %0t: %s port %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_run($sformatf("FAIL at time %0t: %s count %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic add_entry(input port_id_t p, input l2_op_t op, input int a,
                             input data_t d, input tag_t t, input data_t res);
        stim_table.push_back('{p, op, addr_t'(a), d, t, res});
    endtask

    task automatic build_table();
        // Write then read from another port
        add_entry(0, op_write, 5, 32'h1111_0005, 1, '0);
        add_entry(2, op_read, 5, '0, 6, 32'h1111_0005);
        // LR/SC pair succeeds and a second SC finds no reservation
        add_entry(1, op_lr, 9, '0, 2, fill_word(9));
        add_entry(1, op_sc, 9, 32'h2222_0009, 3, 32'd1);
        add_entry(3, op_read, 9, '0, 4, 32'h2222_0009);
        add_entry(1, op_sc, 9, 32'h2bad_0009, 4, 32'd0);
        add_entry(2, op_read, 9, '0, 7, 32'h2222_0009);
        // SC with no LR at all
        add_entry(2, op_sc, 12, 32'h3333_000c, 5, 32'd0);
        add_entry(0, op_read, 12, '0, 0, fill_word(12));
        // Reservation lost to another port's write
        add_entry(3, op_lr, 20, '0, 1, fill_word(20));
        add_entry(0, op_write, 20, 32'h4444_0014, 2, '0);
        add_entry(3, op_sc, 20, 32'h5555_0014, 7, 32'd0);
        add_entry(1, op_read, 20, '0, 3, 32'h4444_0014);
    endtask

    task automatic push_req(input port_id_t p, input l2_op_t op, input addr_t a,
                            input data_t d, input tag_t t);
        int cycles;
        cycles = 0;
        while (!req_ready[p]) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run($sformatf("Timeout: port %0d queue never became ready", p));
            end
        end
        req_addr[p]  = a;
        req_op[p]    = op;
        req_wdata[p] = d;
        req_tag[p]   = t;
        req_valid[p] = 1'b1;
        @(posedge clk);
        #1;
        req_valid[p] = 1'b0;
    endtask

    task automatic wait_done(input l2_op_t op, input port_id_t p, input int wr_before);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            cycles++;
            case (op)
                op_sc:    done = sc_done[p];
                op_write: done = (wr_count > wr_before);
                default:  done = rsp_valid[p];
            endcase
            if (!done && cycles > TIMEOUT) begin
                stop_run($sformatf("Timeout: %s on port %0d never finished", op.name(), p));
            end
        end
    endtask

    task automatic apply_entry(input int idx, input entry_t e);
        int    wr_before;
        string what;
        wr_before = wr_count;
        what      = $sformatf("entry %0d %s", idx, e.op.name());
        push_req(e.port, e.op, e.addr, e.wdata, e.tag);
        wait_done(e.op, e.port, wr_before);
        case (e.op)
            op_sc: begin
                check_sc(sc_ok[e.port], e.result[0], what);
            end
            op_write: begin
                check_port(port_id_t'(last_wr_id >> `L2_TAG_W), e.port, what);
                check_tag(tag_t'(last_wr_id), e.tag, what);
            end
            default: begin
                check_data(rsp_data[e.port], e.result, what);
                check_tag(rsp_tag[e.port], e.tag, what);
                expected_rsp++;
            end
        endcase
        // A failed SC never reaches memory
        if (e.op != op_sc || e.result[0]) begin
            expected_hs++;
        end
    endtask

    task automatic run_parallel_reads();
        int           cycles;
        logic [N-1:0] got;
        for (int p = 0; p < N; p++) begin
            req_addr[p] = addr_t'(40 + p);
            req_op[p]   = op_read;
            req_tag[p]  = tag_t'(p + 3);
        end
        req_valid = '1;
        @(posedge clk);
        #1;
        req_valid    = '0;
        expected_hs  += N;
        expected_rsp += N;
        got    = '0;
        cycles = 0;
        while (got != '1) begin
            @(posedge clk);
            #1;
            cycles++;
            for (int p = 0; p < N; p++) begin
                if (rsp_valid[p]) begin
                    if (got[p]) begin
                        stop_run($sformatf("Port %0d received a second read return", p));
                    end
                    check_data(rsp_data[p], fill_word(40 + p), "parallel read");
                    check_tag(rsp_tag[p], tag_t'(p + 3), "parallel read");
                    got[p] = 1'b1;
                end
            end
            if (got != '1 && cycles > TIMEOUT) begin
                stop_run("Timeout: parallel reads did not all return");
            end
        end
    endtask

    task automatic run_rotation();
        int       cycles;
        port_id_t prev;
        port_id_t cur;
        hs_ids.delete();
        // Four reads per port keep every queue busy
        for (int k = 0; k < 4; k++) begin
            cycles = 0;
            while (req_ready != '1) begin
                @(posedge clk);
                #1;
                cycles++;
                if (cycles > TIMEOUT) begin
                    stop_run("Timeout: queues stayed full during rotation test");
                end
            end
            for (int p = 0; p < N; p++) begin
                req_addr[p] = addr_t'(48 + 4 * p + k);
                req_op[p]   = op_read;
                req_tag[p]  = tag_t'(k);
            end
            req_valid = '1;
            @(posedge clk);
            #1;
            req_valid = '0;
        end
        expected_hs  += 4 * N;
        expected_rsp += 4 * N;
        cycles = 0;
        while (hs_ids.size() < 4 * N || rsp_total < expected_rsp) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_run("Timeout: rotation reads did not drain");
            end
        end
        for (int i = 1; i < hs_ids.size(); i++) begin
            prev = port_id_t'(hs_ids[i-1] >> `L2_TAG_W);
            cur  = port_id_t'(hs_ids[i] >> `L2_TAG_W);
            check_port(cur, port_id_t'((int'(prev) + 1) % N), "round-robin order");
        end
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = '0;
        for (int p = 0; p < N; p++) begin
            req_addr[p]  = '0;
            req_op[p]    = op_read;
            req_wdata[p] = '0;
            req_tag[p]   = '0;
        end
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_id    = '0;
        mem_rsp_data  = '0;
        for (int k = 0; k < 3; k++) begin
            pipe_v[k] = 1'b0;
        end
        for (int a = 0; a < 64; a++) begin
            mem_model[a] = fill_word(a);
        end
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (stim_table[i]) begin
            apply_entry(i, stim_table[i]);
        end
        run_parallel_reads();
        run_rotation();

        // Nothing lost or duplicated across all stalls
        check_count(hs_count, expected_hs, "memory handshake");
        check_count(rsp_total, expected_rsp, "read return");

        if (uut.checks.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", uut.checks.fail_count);
            $display("*** FAILED ***");
            $fatal(1, "assertion failures");
        end
    end

endmodule
